//--- opl_timer_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the timer section
// Register addresses, control and status bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package opl_timer_pkg;

  // Register map, only the timer registers are decoded
  typedef enum logic [7:0] {
    REG_TIMER_A    = 8'h02, // Timer A start value
    REG_TIMER_B    = 8'h03, // Timer B start value
    REG_TIMER_CTRL = 8'h04  // IRQ reset, masks, start bits
  } opl_reg_addr_t;

  // Control register bits
  localparam int CTRL_IRQ_RST = 7; // Clear both flags, rest of write ignored
  localparam int CTRL_MASK_A  = 6; // Hide flag A
  localparam int CTRL_MASK_B  = 5; // Hide flag B
  localparam int CTRL_START_B = 1; // Run timer B
  localparam int CTRL_START_A = 0; // Run timer A

  // Status byte bits, low bits read zero
  localparam int STAT_IRQ    = 7;
  localparam int STAT_FLAG_A = 6;
  localparam int STAT_FLAG_B = 5;

  // cen16 pulses per sample
  localparam int SLOT_COUNT = 18;

endpackage

//--- opl_timing.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing generator for cen16 and zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opl_timing import opl_timer_pkg::*; #(
  parameter int CEN_DIV = 4 // clk cycles per cen16
) (
  input  logic clk,
  input  logic rst,
  output logic cen16,  // One clk cycle in every CEN_DIV
  output logic zero    // Slot zero marker, once per sample
);

  localparam int PW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;  // Prescaler width
  localparam int SW = $clog2(SLOT_COUNT);                  // Slot counter width

  logic [PW-1:0] pre_cnt;  // Prescaler count
  logic [SW-1:0] slot_cnt; // Current slot

  // Prescaler wraps after CEN_DIV cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      pre_cnt <= '0;
    end else if (cen16) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  assign cen16 = (pre_cnt == PW'(CEN_DIV - 1)); // Last prescaler cycle

  // Slot counter steps once per cen16
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_cnt <= '0;
    end else if (cen16) begin
      if (slot_cnt == SW'(SLOT_COUNT - 1)) slot_cnt <= '0; // End of sample
      else slot_cnt <= slot_cnt + 1'b1;
    end
  end

  assign zero = cen16 && (slot_cnt == '0); // Only with a cen16 pulse

endmodule

//--- opl_reg_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus write decoder for the timer registers
// Address latch, start values, control bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opl_reg_if import opl_timer_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr,         // Write strobe, one cycle per write
  input  logic       a0,         // Low selects address, high selects data
  input  logic [7:0] din,
  output logic [7:0] value_a,    // Timer A start value
  output logic [7:0] value_b,    // Timer B start value
  output logic       load_a,     // Timer A running
  output logic       load_b,     // Timer B running
  output logic       flagen_a,   // Flag A visible
  output logic       flagen_b,   // Flag B visible
  output logic       clr_flag_a, // Flag A clear strobe
  output logic       clr_flag_b  // Flag B clear strobe
);

  logic [7:0] addr;    // Latched register address
  logic       mask_a;  // Flag A hidden
  logic       mask_b;  // Flag B hidden
  logic       clr_irq; // IRQ reset seen on last write
  logic       addr_wr; // Address phase
  logic       data_wr; // Data phase

  assign addr_wr = wr && !a0;
  assign data_wr = wr && a0;

  // Address latch
  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
    end else if (addr_wr) begin
      addr <= din;
    end
  end

  // Data writes go to the latched register
  always_ff @(posedge clk) begin
    if (rst) begin
      value_a <= '0;
      value_b <= '0;
      load_a  <= 1'b0;
      load_b  <= 1'b0;
      mask_a  <= 1'b0;
      mask_b  <= 1'b0;
      clr_irq <= 1'b0;
    end else begin
      clr_irq <= 1'b0; // Strobe lasts one cycle
      if (data_wr) begin
        case (opl_reg_addr_t'(addr))
          REG_TIMER_A: value_a <= din;
          REG_TIMER_B: value_b <= din;
          REG_TIMER_CTRL: begin
            if (din[CTRL_IRQ_RST]) begin
              clr_irq <= 1'b1; // Masks and start bits kept
            end else begin
              mask_a <= din[CTRL_MASK_A];
              mask_b <= din[CTRL_MASK_B];
              load_a <= din[CTRL_START_A];
              load_b <= din[CTRL_START_B];
            end
          end
          default: ; // Other registers not in this block
        endcase
      end
    end
  end

  assign flagen_a   = ~mask_a;
  assign flagen_b   = ~mask_b;
  assign clr_flag_a = clr_irq; // IRQ reset clears both flags
  assign clr_flag_b = clr_irq;

endmodule

//--- opl_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Up-counting timer with reload and flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opl_timer #(
  parameter int EXTRA_BITS = 0 // Low counter bits below the start value
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       cen16,
  input  logic       zero,
  input  logic [7:0] start_value,
  input  logic       load,        // Low holds the start value
  input  logic       clr_flag,
  output logic       flag,        // Sticky overflow flag
  output logic       overflow     // One cycle on the overflow tick
);

  localparam int CW = 8 + EXTRA_BITS; // Counter width

  logic [CW-1:0] cnt;   // Counter
  logic [CW-1:0] init;  // Reload value
  logic [CW-1:0] next;  // Counter plus one
  logic          carry; // Counter at all ones
  logic          step;  // Once per sample

  assign init  = CW'(start_value) << EXTRA_BITS; // Zeros fill low bits
  assign {carry, next} = {1'b0, cnt} + 1'b1;
  assign step  = cen16 && zero;
  assign overflow = load && step && carry; // Only counts while running

  always_ff @(posedge clk) begin
    if (rst || !load) begin
      cnt <= init; // Stopped timer follows start value
    end else if (step) begin
      cnt <= carry ? init : next; // Reload current value on wrap
    end
  end

  // Flag holds until cleared
  always_ff @(posedge clk) begin
    if (rst || clr_flag) begin
      flag <= 1'b0;
    end else if (overflow) begin
      flag <= 1'b1;
    end
  end

endmodule

//--- opl_timers.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer pair with masking, IRQ and status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opl_timers import opl_timer_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cen16,
  input  logic       zero,
  input  logic [7:0] value_a,
  input  logic [7:0] value_b,
  input  logic       load_a,
  input  logic       load_b,
  input  logic       clr_flag_a,
  input  logic       clr_flag_b,
  input  logic       flagen_a,
  input  logic       flagen_b,
  output logic [7:0] dout,       // Status byte
  output logic       overflow_a, // For CSM in the FM core
  output logic       irq_n
);

  logic raw_a, raw_b;   // Flags before masking
  logic flag_a, flag_b; // Visible flags
  logic irq;

  assign flag_a = raw_a & flagen_a; // Mask hides, does not clear
  assign flag_b = raw_b & flagen_b;
  assign irq    = flag_a | flag_b;
  assign irq_n  = ~irq;

  always_comb begin
    dout              = '0; // Unused bits read zero
    dout[STAT_IRQ]    = irq;
    dout[STAT_FLAG_A] = flag_a;
    dout[STAT_FLAG_B] = flag_b;
  end

  // Timer A steps once per sample
  opl_timer #(.EXTRA_BITS(0)) timer_a (
    .clk         (clk),
    .rst         (rst),
    .cen16       (cen16),
    .zero        (zero),
    .start_value (value_a),
    .load        (load_a),
    .clr_flag    (clr_flag_a),
    .flag        (raw_a),
    .overflow    (overflow_a)
  );

  // Timer B is four times slower
  opl_timer #(.EXTRA_BITS(2)) timer_b (
    .clk         (clk),
    .rst         (rst),
    .cen16       (cen16),
    .zero        (zero),
    .start_value (value_b),
    .load        (load_b),
    .clr_flag    (clr_flag_b),
    .flag        (raw_b),
    .overflow    ()
  );

endmodule

//--- opl_timer_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer section top level
// Bus decoder, timing generator, timer pair
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opl_timer_top #(
  parameter int CEN_DIV = 4 // clk cycles per cen16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr,         // CPU write strobe
  input  logic       a0,         // Address or data select
  input  logic [7:0] din,
  output logic [7:0] dout,       // Status byte
  output logic       irq_n,
  output logic       overflow_a  // Timer A overflow pulse
);

  logic       cen16, zero;
  logic [7:0] value_a, value_b;
  logic       load_a, load_b;
  logic       flagen_a, flagen_b;
  logic       clr_flag_a, clr_flag_b;

  opl_timing #(.CEN_DIV(CEN_DIV)) timing_inst (
    .clk   (clk),
    .rst   (rst),
    .cen16 (cen16),
    .zero  (zero)
  );

  opl_reg_if reg_if_inst (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .a0         (a0),
    .din        (din),
    .value_a    (value_a),
    .value_b    (value_b),
    .load_a     (load_a),
    .load_b     (load_b),
    .flagen_a   (flagen_a),
    .flagen_b   (flagen_b),
    .clr_flag_a (clr_flag_a),
    .clr_flag_b (clr_flag_b)
  );

  opl_timers timers_inst (
    .clk        (clk),
    .rst        (rst),
    .cen16      (cen16),
    .zero       (zero),
    .value_a    (value_a),
    .value_b    (value_b),
    .load_a     (load_a),
    .load_b     (load_b),
    .clr_flag_a (clr_flag_a),
    .clr_flag_b (clr_flag_b),
    .flagen_a   (flagen_a),
    .flagen_b   (flagen_b),
    .dout       (dout),
    .overflow_a (overflow_a),
    .irq_n      (irq_n)
  );

endmodule

//--- opl_timer_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the timer section top level
// Clock, reset, bus tasks, directed tests, timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module opl_timer_tb import opl_timer_pkg::*; ();

  localparam int CEN_DIV        = 1;                  // One cen16 per clk
  localparam int TICK           = SLOT_COUNT * CEN_DIV; // clk cycles per timer step
  localparam int TIMEOUT_CYCLES = 20000;              // Well above all tests together

  logic        clk;
  logic        rst;
  logic        wr;
  logic        a0;
  logic [7:0]  din;
  logic [7:0]  dout;
  logic        irq_n;
  logic        overflow_a;
  logic [31:0] rnd_state = 32'h33662db4; // xorshift state
  int          cycle_cnt = 0;

  opl_timer_top #(.CEN_DIV(CEN_DIV)) opl_timer_top_inst (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .a0         (a0),
    .din        (din),
    .dout       (dout),
    .irq_n      (irq_n),
    .overflow_a (overflow_a)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped by timeout");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Start values 0xF0 to 0xFF keep the runs short
  function automatic logic [7:0] next_start_value();
    rnd_state = xorshift(rnd_state);
    return {4'hF, rnd_state[3:0]};
  endfunction

  function automatic logic [7:0] ctrl_byte(input logic irq_rst, input logic mask_a,
                                           input logic mask_b, input logic start_a,
                                           input logic start_b);
    logic [7:0] b;
    b               = 8'h00;
    b[CTRL_IRQ_RST] = irq_rst;
    b[CTRL_MASK_A]  = mask_a;
    b[CTRL_MASK_B]  = mask_b;
    b[CTRL_START_A] = start_a;
    b[CTRL_START_B] = start_b;
    return b;
  endfunction

  task automatic check_value(input string test, input int exp, input int act);
    assert (exp == act) else begin
      $display("Error in %s: expected %0h, actual %0h", test, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Check failed in %s", test);
    end
  endtask

  // Address write then data write, inputs change on the falling edge
  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    wr  = 1'b1;
    a0  = 1'b0;
    din = addr;
    @(negedge clk);
    a0  = 1'b1;
    din = data;
    @(negedge clk);
    wr  = 1'b0;
    a0  = 1'b0;
    din = 8'h00;
  endtask

  // Flag must stay clear before clear_until and be set at set_by
  task automatic watch_flag(input string test, input logic use_b, input int clear_until,
                            input int set_by, input int ovf_exp);
    int   ovf_seen;
    logic flag;
    ovf_seen = 0;
    for (int c = 1; c <= set_by; c++) begin
      @(negedge clk);
      if (overflow_a) ovf_seen++;
      flag = use_b ? dout[STAT_FLAG_B] : dout[STAT_FLAG_A];
      if (c < clear_until) check_value(test, 0, int'(flag));
    end
    flag = use_b ? dout[STAT_FLAG_B] : dout[STAT_FLAG_A];
    check_value(test, 1, int'(flag));
    check_value(test, 1, int'(dout[STAT_IRQ]));
    check_value(test, 0, int'(irq_n));
    check_value(test, ovf_exp, ovf_seen); // overflow_a pulses in the window
  endtask

  task automatic stop_and_clear(input string test);
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    @(negedge clk); // Clear strobe lands one cycle after the write
    check_value(test, 0, int'(dout));
    check_value(test, 1, int'(irq_n));
  endtask

  task automatic test_reset();
    check_value("reset", 0, int'(dout));
    check_value("reset", 1, int'(irq_n));
    check_value("reset", 0, int'(overflow_a));
  endtask

  // Timer A, then IRQ reset while it keeps running
  task automatic test_timer_a_and_irq_reset();
    logic [7:0] v;
    int         s;
    v = next_start_value();
    s = 256 - int'(v);
    write_reg(REG_TIMER_A, v);
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    watch_flag("timer_a", 1'b0, (s - 1) * TICK, (s + 1) * TICK, 1);
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    @(negedge clk);
    check_value("irq_reset", 0, int'(dout));
    check_value("irq_reset", 1, int'(irq_n));
    watch_flag("irq_reset", 1'b0, (s - 3) * TICK, (s + 1) * TICK, 1); // Next wrap
    stop_and_clear("irq_reset");
  endtask

  task automatic test_timer_b();
    logic [7:0] v;
    int         s;
    v = next_start_value();
    s = 4 * (256 - int'(v)); // Two extra low bits
    write_reg(REG_TIMER_B, v);
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    watch_flag("timer_b", 1'b1, (s - 1) * TICK, (s + 1) * TICK, 0);
    stop_and_clear("timer_b");
  endtask

  task automatic test_mask();
    logic [7:0] v;
    int         s;
    int         ovf_seen;
    v        = next_start_value();
    s        = 256 - int'(v);
    ovf_seen = 0;
    write_reg(REG_TIMER_A, v);
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
    for (int c = 1; c <= (s + 1) * TICK; c++) begin
      @(negedge clk);
      if (overflow_a) ovf_seen++;
      check_value("mask", 0, int'(dout[STAT_FLAG_A]));
      check_value("mask", 1, int'(irq_n));
    end
    check_value("mask", 1, ovf_seen);
    // Unmask only, the held flag shows up
    write_reg(REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    check_value("mask", 1, int'(dout[STAT_FLAG_A]));
    check_value("mask", 0, int'(irq_n));
    stop_and_clear("mask");
  endtask

  task automatic test_stop();
    write_reg(REG_TIMER_A, 8'hFF);
    write_reg(REG_TIMER_B, 8'hFF);
    write_reg(8'h05, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b1)); // Unused address
    for (int c = 1; c <= 300 * TICK; c++) begin
      @(negedge clk);
      check_value("stop", 0, int'(dout));
      check_value("stop", 1, int'(irq_n));
    end
  endtask

  initial begin
    rst = 1'b1;
    wr  = 1'b0;
    a0  = 1'b0;
    din = 8'h00;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset();
    test_timer_a_and_irq_reset();
    test_timer_b();
    test_mask();
    test_stop();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- list.f
opl_timer_pkg.sv
opl_timing.sv
opl_reg_if.sv
opl_timer.sv
opl_timers.sv
opl_timer_top.sv
opl_timer_tb.sv

//--- run.sh
#!/bin/sh
# Build the timer section testbench with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module opl_timer_tb -f list.f -o opl_timer_sim \
  > build.log 2>&1 \
  && ./obj_dir/opl_timer_sim > sim.log 2>&1 \
  || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
